// File: src.f
verilog/pe_pkg.sv
verilog/pe_ctrl.sv
verilog/beat_counter.sv
verilog/weight_bank.sv
verilog/act_window.sv
verilog/outer_product.sv
verilog/pe_top.sv
verification/pe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pe_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/pe_tb.sv
`timescale 1ns/1ps

module pe_tb;

    localparam int count_width    = 16;
    localparam int frac_bits      = 8;
    localparam int clk_half       = 2;
    localparam int drive_delay    = 1;
    localparam int reset_cycles   = 8;
    localparam int result_timeout = 40;

    // phases of the reference model
    localparam int ph_idle   = 0;
    localparam int ph_weight = 1;
    localparam int ph_image  = 2;

    logic                   clk;
    logic                   irst_n;
    logic                   in_valid;
    pe_pkg::pe_in_t         in_beat;
    logic [count_width-1:0] frame_len;
    logic                   out_valid;
    pe_pkg::pe_out_t        out_beat;

    // reference state, weight slots and the four-group window
    pe_pkg::weight_beat_t m_w   [4];
    pe_pkg::act_beat_t    m_win [4];
    int                   m_phase;
    int                   m_idx;

    // results still owed by the DUT, with the cycle each one must appear in
    pe_pkg::pe_out_t exp_q [$];
    int              cyc_q [$];

    int          cyc;
    int          errors;
    int          checks;
    int          results;
    int          tests;

    pe_top #(
        .count_width (count_width),
        .frac_bits   (frac_bits)
    ) u_dut (
        .clk       (clk),
        .irst_n    (irst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .frame_len (frame_len),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    // cycle number of the most recent rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            $display("MISMATCH %s expected %h actual %h", name, expv, actv);
            errors++;
        end
    endtask

    task automatic compare_result(input pe_pkg::pe_out_t e);
        for (int k = 0; k < 16; k++) begin
            check_value($sformatf("out_beat.data[%0d]", k), $unsigned(e.data[k]),
                        $unsigned(out_beat.data[k]));
            check_value($sformatf("out_beat.cols[%0d]", k), e.cols[k], out_beat.cols[k]);
            check_value($sformatf("out_beat.rows[%0d]", k), e.rows[k], out_beat.rows[k]);
        end
        check_value("out_beat.channel", e.channel, out_beat.channel);
    endtask

    // out_valid and out_beat are registered, so the falling edge sees them settled
    always @(negedge clk) begin : result_monitor
        pe_pkg::pe_out_t e;
        int              ec;
        if (irst_n && out_valid) begin
            results++;
            if (exp_q.size() == 0) begin
                $display("out_valid high at cycle %0d while no result was due", cyc);
                errors++;
            end else begin
                e  = exp_q.pop_front();
                ec = cyc_q.pop_front();
                if (cyc != ec) begin
                    $display("result arrived in cycle %0d but was due in cycle %0d", cyc, ec);
                    errors++;
                end
                compare_result(e);
            end
        end
    end

    // products are sliced by an arithmetic shift, coordinates summed and reduced mod 32
    function automatic pe_pkg::pe_out_t expected_result(input logic [5:0] ch);
        pe_pkg::pe_out_t   r;
        logic signed [31:0] p;
        int                k;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                k = i * 4 + j;
                p = 32'($signed(m_w[i].weight)) * 32'($signed(m_win[i].act[j]));
                r.data[k] = 16'(p >>> frac_bits);
                r.cols[k] = 5'((int'(m_win[i].cols[j]) + int'(m_w[i].col)) % 32);
                r.rows[k] = 5'((int'(m_win[i].rows[j]) + int'(m_w[i].row)) % 32);
            end
        end
        r.channel = ch;
        return r;
    endfunction

    // the first beat after reset is already weight 0 of the first load
    task automatic model_accept(input pe_pkg::pe_in_t b);
        if (m_phase == ph_idle) begin
            m_w[0]  = b.weight;
            m_idx   = 1;
            m_phase = ph_weight;
        end else if (m_phase == ph_weight) begin
            m_w[m_idx] = b.weight;
            if (m_idx == 3) begin
                m_phase = ph_image;
                m_idx   = 0;
            end else begin
                m_idx++;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                m_win[i] = m_win[i + 1];
            end
            m_win[3] = b.acts;
            if (m_idx >= 3) begin
                exp_q.push_back(expected_result(b.channel));
                cyc_q.push_back(cyc + 1);
            end
            // the window is kept across the reload, only the index restarts
            if (m_idx == int'(frame_len) - 1) begin
                m_phase = ph_weight;
                m_idx   = 0;
            end else begin
                m_idx++;
            end
        end
    endtask

    function automatic pe_pkg::pe_in_t random_beat();
        pe_pkg::pe_in_t b;
        b.weight.weight = pe_pkg::word_t'($urandom);
        b.weight.col    = pe_pkg::coord_t'($urandom);
        b.weight.row    = pe_pkg::coord_t'($urandom);
        for (int j = 0; j < 4; j++) begin
            b.acts.act[j]  = pe_pkg::word_t'($urandom);
            b.acts.cols[j] = pe_pkg::coord_t'($urandom);
            b.acts.rows[j] = pe_pkg::coord_t'($urandom);
        end
        b.channel = 6'($urandom);
        return b;
    endfunction

    // called just after a rising edge, the beat is taken on the next one
    task automatic drive_beat(input pe_pkg::pe_in_t b);
        in_beat  = b;
        in_valid = 1'b1;
        model_accept(b);
        @(posedge clk);
        #drive_delay;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic load_weights(input int max_gap);
        for (int i = 0; i < 4; i++) begin
            idle_cycles($urandom_range(0, max_gap));
            drive_beat(random_beat());
        end
    endtask

    task automatic stream_frame(input int len, input int max_gap);
        frame_len = count_width'(len);
        for (int n = 0; n < len; n++) begin
            idle_cycles($urandom_range(0, max_gap));
            drive_beat(random_beat());
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < result_timeout) begin
            @(posedge clk);
            #drive_delay;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d results still missing on out_valid", exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic check_count(input int first, input int want);
        if (results - first != want) begin
            $display("expected %0d results but out_valid gave %0d", want, results - first);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int first_errors);
        tests++;
        if (errors == first_errors) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - first_errors);
        end
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        if (out_beat !== '0) begin
            $display("MISMATCH out_beat expected %h actual %h", pe_pkg::pe_out_t'(0), out_beat);
            errors++;
        end
        repeat (10) begin
            idle_cycles(1);
            check_value("out_valid", 32'd0, {31'd0, out_valid});
        end
        finish_test("reset_state", e0);
    endtask

    task automatic basic_frame();
        int e0;
        int r0;
        e0 = errors;
        r0 = results;
        load_weights(0);
        stream_frame(6, 0);
        wait_results();
        check_count(r0, 3);
        finish_test("basic_frame", e0);
    endtask

    // most negative, most positive and minus one, plus a sign flip from the table
    function automatic pe_pkg::word_t edge_word(input int n);
        pe_pkg::word_t table_w [4];
        table_w = '{16'h8000, 16'h7fff, 16'hffff, 16'h8001};
        return table_w[n % 4];
    endfunction

    task automatic fixed_point();
        pe_pkg::pe_in_t b;
        int             e0;
        int             r0;
        e0 = errors;
        r0 = results;
        for (int i = 0; i < 4; i++) begin
            b               = random_beat();
            b.weight.weight = edge_word(i);
            b.weight.col    = 5'(31 - i);
            b.weight.row    = 5'(28 + i);
            drive_beat(b);
        end
        frame_len = count_width'(5);
        for (int n = 0; n < 5; n++) begin
            b = random_beat();
            // coordinates near the top of the range make every sum wrap
            for (int j = 0; j < 4; j++) begin
                b.acts.act[j]  = edge_word(n + j + 1);
                b.acts.cols[j] = 5'(31 - j);
                b.acts.rows[j] = 5'(16 + j);
            end
            drive_beat(b);
        end
        wait_results();
        check_count(r0, 2);
        finish_test("fixed_point", e0);
    endtask

    task automatic gapped_input();
        int e0;
        int r0;
        e0 = errors;
        r0 = results;
        load_weights(3);
        stream_frame(7, 3);
        wait_results();
        check_count(r0, 4);
        finish_test("gapped_input", e0);
    endtask

    // second frame starts with the window left over from the first one
    task automatic back_to_back();
        int e0;
        int r0;
        e0 = errors;
        r0 = results;
        load_weights(0);
        stream_frame(6, 0);
        load_weights(0);
        stream_frame(5, 0);
        wait_results();
        check_count(r0, 5);
        finish_test("back_to_back", e0);
    endtask

    initial begin
        void'($urandom(32'h7865d1dc));
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        results   = 0;
        tests     = 0;
        m_phase   = ph_idle;
        m_idx     = 0;
        for (int i = 0; i < 4; i++) begin
            m_w[i]   = '0;
            m_win[i] = '0;
        end
        irst_n    = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        frame_len = count_width'(6);
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        irst_n = 1'b1;
        reset_state();
        basic_frame();
        fixed_point();
        gapped_input();
        back_to_back();
        $display("tests %0d, checks %0d, results %0d, errors %0d", tests, checks, results,
                 errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/pe_top.sv
`timescale 1ns/1ps

module pe_top #(
    parameter int count_width = 16,
    parameter int frac_bits   = 8
) (
    input  logic                   clk,
    input  logic                   irst_n,
    input  logic                   in_valid,
    input  pe_pkg::pe_in_t         in_beat,
    input  logic [count_width-1:0] frame_len,
    output logic                   out_valid,
    output pe_pkg::pe_out_t        out_beat
);

    logic                   weight_we;
    logic                   act_we;
    logic                   product_en;
    logic                   count_en;
    logic                   count_clr;
    logic [1:0]             weight_slot;
    logic [count_width-1:0] count;

    // the product stage works on the state as updated by the current beat
    pe_pkg::weight_beat_t [pe_pkg::lanes-1:0] weights_next;
    pe_pkg::act_beat_t    [pe_pkg::lanes-1:0] window_next;

    pe_ctrl #(
        .count_width (count_width)
    ) u_ctrl (
        .clk         (clk),
        .irst_n      (irst_n),
        .in_valid    (in_valid),
        .frame_len   (frame_len),
        .count       (count),
        .weight_we   (weight_we),
        .act_we      (act_we),
        .product_en  (product_en),
        .count_en    (count_en),
        .count_clr   (count_clr),
        .weight_slot (weight_slot)
    );

    beat_counter #(
        .count_width (count_width)
    ) u_counter (
        .clk       (clk),
        .irst_n    (irst_n),
        .count_en  (count_en),
        .count_clr (count_clr),
        .count     (count)
    );

    // registered copies stay inside the banks, only the next-state views leave
    weight_bank u_weights (
        .clk          (clk),
        .irst_n       (irst_n),
        .weight_we    (weight_we),
        .weight_slot  (weight_slot),
        .weight       (in_beat.weight),
        .weights      (),
        .weights_next (weights_next)
    );

    act_window u_window (
        .clk         (clk),
        .irst_n      (irst_n),
        .act_we      (act_we),
        .acts        (in_beat.acts),
        .window      (),
        .window_next (window_next)
    );

    outer_product #(
        .frac_bits (frac_bits)
    ) u_product (
        .clk        (clk),
        .irst_n     (irst_n),
        .product_en (product_en),
        .weights    (weights_next),
        .window     (window_next),
        .channel    (in_beat.channel),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

endmodule

// File: verilog/outer_product.sv
`timescale 1ns/1ps

module outer_product #(
    parameter int frac_bits = 8
) (
    input  logic                                     clk,
    input  logic                                     irst_n,
    input  logic                                     product_en,
    input  pe_pkg::weight_beat_t [pe_pkg::lanes-1:0] weights,
    input  pe_pkg::act_beat_t    [pe_pkg::lanes-1:0] window,
    input  logic [pe_pkg::chan_width-1:0]            channel,
    output logic                                     out_valid,
    output pe_pkg::pe_out_t                          out_beat
);

    localparam int prod_width = 2 * pe_pkg::word_width;

    // full precision products before the fixed-point slice
    logic signed [prod_width-1:0] full_prod [pe_pkg::lanes][pe_pkg::lanes];

    pe_pkg::pe_out_t result;

    // weight i pairs only with the four activations of window group i
    always_comb begin
        int k;
        result = '0;
        for (int i = 0; i < pe_pkg::lanes; i++) begin
            for (int j = 0; j < pe_pkg::lanes; j++) begin
                k = i * pe_pkg::lanes + j;
                full_prod[i][j] = $signed(weights[i].weight) * $signed(window[i].act[j]);
                // drop frac_bits fraction bits and keep one word above them
                result.data[k] = full_prod[i][j][frac_bits +: pe_pkg::word_width];
                // output position is activation position plus kernel offset, wrapping
                result.cols[k] = window[i].cols[j] + weights[i].col;
                result.rows[k] = window[i].rows[j] + weights[i].row;
            end
        end
        result.channel = channel;
    end

    // single register stage, results appear the cycle after the producing beat
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            out_valid <= 1'b0;
            out_beat  <= '0;
        end else begin
            out_valid <= product_en;
            // hold the last result between producing beats
            if (product_en) begin
                out_beat <= result;
            end
        end
    end

endmodule

// File: verilog/act_window.sv
`timescale 1ns/1ps

module act_window (
    input  logic                                  clk,
    input  logic                                  irst_n,
    input  logic                                  act_we,
    input  pe_pkg::act_beat_t                     acts,
    output pe_pkg::act_beat_t [pe_pkg::lanes-1:0] window,
    // next-state view, already shifted by a group accepted on this beat
    output pe_pkg::act_beat_t [pe_pkg::lanes-1:0] window_next
);

    // slot lanes-1 takes the newest group, slot 0 holds the oldest
    always_comb begin
        window_next = window;
        if (act_we) begin
            for (int i = 0; i < pe_pkg::lanes - 1; i++) begin
                window_next[i] = window[i + 1];
            end
            window_next[pe_pkg::lanes-1] = acts;
        end
    end

    // the window survives a weight reload and only reset empties it
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            window <= '0;
        end else begin
            window <= window_next;
        end
    end

endmodule

// File: verilog/weight_bank.sv
`timescale 1ns/1ps

module weight_bank (
    input  logic                                     clk,
    input  logic                                     irst_n,
    input  logic                                     weight_we,
    input  logic [1:0]                               weight_slot,
    input  pe_pkg::weight_beat_t                     weight,
    output pe_pkg::weight_beat_t [pe_pkg::lanes-1:0] weights,
    // next-state view, already holds a weight written on this beat
    output pe_pkg::weight_beat_t [pe_pkg::lanes-1:0] weights_next
);

    // only the addressed slot changes, the others keep their last load
    always_comb begin
        weights_next = weights;
        if (weight_we) begin
            weights_next[weight_slot] = weight;
        end
    end

    // all slots read zero until the first load writes them
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            weights <= '0;
        end else begin
            weights <= weights_next;
        end
    end

endmodule

// File: verilog/beat_counter.sv
`timescale 1ns/1ps

module beat_counter #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   irst_n,
    input  logic                   count_en,
    input  logic                   count_clr,
    output logic [count_width-1:0] count
);

    // counts accepted beats only, idle cycles between beats leave it alone
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            count <= '0;
        end else if (count_clr) begin
            // the clearing beat closes its phase, the next beat starts at zero
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    // a frame longer than the counter range would silently restart the index
    assert property (@(posedge clk) disable iff (!irst_n)
        (count_en && !count_clr) |-> (count != '1))
        else $error("beat counter wrapped, frame_len too large for count_width");

endmodule

// File: verilog/pe_ctrl.sv
`timescale 1ns/1ps

module pe_ctrl #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   irst_n,
    input  logic                   in_valid,
    input  logic [count_width-1:0] frame_len,
    input  logic [count_width-1:0] count,
    output logic                   weight_we,
    output logic                   act_we,
    output logic                   product_en,
    output logic                   count_en,
    output logic                   count_clr,
    output logic [1:0]             weight_slot
);

    pe_pkg::pe_state_t state;
    pe_pkg::pe_state_t state_next;

    logic [count_width-1:0] frame_last;
    logic                   weight_done;
    logic                   frame_done;
    logic                   window_full;

    // count holds the in-phase index of the beat now on the inputs
    assign frame_last  = frame_len - 1'b1;
    assign weight_done = (count == count_width'(pe_pkg::lanes - 1));
    assign frame_done  = (count == frame_last);

    // the window holds lanes groups once index lanes-1 has shifted in
    assign window_full = (count >= count_width'(pe_pkg::lanes - 1));

    // beat k of a weight load goes to slot k, and idle only ever sees index 0
    assign weight_slot = count[1:0];

    // strobes follow in_valid in the same cycle so the data modules act on this edge
    always_comb begin
        state_next = state;
        weight_we  = 1'b0;
        act_we     = 1'b0;
        product_en = 1'b0;
        count_en   = in_valid;
        count_clr  = 1'b0;
        case (state)
            pe_pkg::st_idle: begin
                // the first beat ever is already weight 0
                if (in_valid) begin
                    weight_we  = 1'b1;
                    state_next = pe_pkg::st_load_weight;
                end
            end
            pe_pkg::st_load_weight: begin
                weight_we = in_valid;
                if (in_valid && weight_done) begin
                    count_clr  = 1'b1;
                    state_next = pe_pkg::st_load_image;
                end
            end
            pe_pkg::st_load_image: begin
                act_we     = in_valid;
                product_en = in_valid && window_full;
                // last beat of the frame, the window is kept for the next frame
                if (in_valid && frame_done) begin
                    count_clr  = 1'b1;
                    state_next = pe_pkg::st_load_weight;
                end
            end
            default: begin
                count_en   = 1'b0;
                state_next = pe_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            state <= pe_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // a beat belongs either to the weight bank or to the window, never both
    assert property (@(posedge clk) disable iff (!irst_n) !(weight_we && act_we))
        else $error("weight_we and act_we high on the same beat");

endmodule

// File: verilog/pe_pkg.sv
package pe_pkg;

    // width of a weight, an activation and a truncated product
    localparam int word_width = 16;

    // one spatial coordinate, all coordinate sums wrap modulo 2**coord_width
    localparam int coord_width = 5;

    // weights per load and activations per group, the array is lanes by lanes
    localparam int lanes = 4;

    // input channel tag carried from the image beat to its result
    localparam int chan_width = 6;

    // idle is left on the first weight beat and never entered again
    typedef enum logic [1:0] {
        st_idle        = 2'd0,
        st_load_weight = 2'd1,
        st_load_image  = 2'd2
    } pe_state_t;

    // named signed word so that elements of packed arrays keep their sign
    typedef logic signed [word_width-1:0] word_t;
    typedef logic [coord_width-1:0] coord_t;

    // one weight with its kernel coordinate
    typedef struct packed {
        word_t  weight;
        coord_t col;
        coord_t row;
    } weight_beat_t;

    // one activation group, entry j of each field belongs to activation j
    typedef struct packed {
        word_t  [lanes-1:0] act;
        coord_t [lanes-1:0] cols;
        coord_t [lanes-1:0] rows;
    } act_beat_t;

    // everything the environment presents on one input beat
    typedef struct packed {
        weight_beat_t            weight;
        act_beat_t               acts;
        logic [chan_width-1:0]   channel;
    } pe_in_t;

    // result of one producing beat, element i*lanes+j is weight i times activation j
    typedef struct packed {
        word_t  [lanes*lanes-1:0] data;
        coord_t [lanes*lanes-1:0] cols;
        coord_t [lanes*lanes-1:0] rows;
        logic   [chan_width-1:0]  channel;
    } pe_out_t;

endpackage
